/* source/vrx_defines.svh */
`ifndef VRX_DEFINES_SVH
`define VRX_DEFINES_SVH

// Wishbone word addresses
`define VRX_REG_CMD        3'd0
`define VRX_REG_TIME_HI    3'd1
`define VRX_REG_TIME_LO    3'd2   // Write pushes the command
`define VRX_REG_CLEAR      3'd3
`define VRX_REG_STATUS     3'd4

// Width of one DSP sample
`define VRX_SAMPLE_W       32

// Queue depths as log2
`define VRX_CMD_DEPTH_LOG2 4
`define VRX_SMP_DEPTH_LOG2 4

`endif

/* source/vrx_pkg.sv */
`default_nettype none
`include "vrx_defines.svh"

package vrx_pkg;

   // Encodings match the status readback
   typedef enum logic [2:0] {
      st_idle         = 3'd0,
      st_waiting      = 3'd1,
      st_running      = 3'd2,
      st_overrun      = 3'd4,
      st_broken_chain = 3'd5,
      st_late_cmd     = 3'd6
   } vrx_state_t;

   typedef struct packed {
      logic        send_imm;
      logic        chain;         // Follow-on command expected
      logic [29:0] num_lines;
      logic [63:0] trigger_time;
   } vrx_cmd_t;

   typedef struct packed {
      logic overrun;
      logic broken_chain;
      logic late_cmd;
      logic cmd_done;
   } vrx_flags_t;

   typedef struct packed {
      vrx_flags_t               flags;
      logic [63:0]              vita_time;   // Time tag
      logic [`VRX_SAMPLE_W-1:0] sample;
   } vrx_smp_entry_t;

endpackage

`default_nettype wire

/* source/vrx_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vrx_defines.svh"

module vrx_wb_regs
(
   input  wire                              clk,
   input  wire                              arst_n_i,
   input  wire                              wb_cyc_i,
   input  wire                              wb_stb_i,
   input  wire                              wb_we_i,
   input  wire  [2:0]                       wb_adr_i,
   input  wire  [31:0]                      wb_dat_i,
   output logic [31:0]                      wb_dat_o,
   output logic                             wb_ack_o,
   input  wire  vrx_pkg::vrx_state_t        state_i,
   input  wire  [`VRX_CMD_DEPTH_LOG2:0]     cmd_count_i,
   input  wire                              cmd_full_i,
   output logic                             cmd_push_o,
   output vrx_pkg::vrx_cmd_t                cmd_o,
   output logic                             clear_o
);

   logic        req;
   logic        wr_ack;
   logic [31:0] cmd_reg;
   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        push_req;
   logic        cmd_dropped;

   assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr_ack = wb_ack_o & wb_cyc_i & wb_stb_i & wb_we_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= req;   // Single-cycle ack, no wait states
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cmd_reg <= '0;
         time_hi <= '0;
         time_lo <= '0;
      end
      else if (wr_ack)
      begin
         case (wb_adr_i)
            `VRX_REG_CMD:     cmd_reg <= wb_dat_i;
            `VRX_REG_TIME_HI: time_hi <= wb_dat_i;
            `VRX_REG_TIME_LO: time_lo <= wb_dat_i;
            default:          ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         push_req    <= 1'b0;
         clear_o     <= 1'b0;
         cmd_dropped <= 1'b0;
      end
      else
      begin
         push_req <= wr_ack && (wb_adr_i == `VRX_REG_TIME_LO);
         clear_o  <= wr_ack && (wb_adr_i == `VRX_REG_CLEAR);
         if (clear_o)
            cmd_dropped <= 1'b0;
         else if (push_req && cmd_full_i)
            cmd_dropped <= 1'b1;   // Sticky until cleared
      end
   end

   assign cmd_push_o = push_req & ~cmd_full_i;
   assign cmd_o      = '{send_imm: cmd_reg[31], chain: cmd_reg[30], num_lines: cmd_reg[29:0],
                         trigger_time: {time_hi, time_lo}};

   always_comb
   begin
      wb_dat_o = '0;
      case (wb_adr_i)
         `VRX_REG_CMD:     wb_dat_o = cmd_reg;
         `VRX_REG_TIME_HI: wb_dat_o = time_hi;
         `VRX_REG_TIME_LO: wb_dat_o = time_lo;
         `VRX_REG_STATUS:
         begin
            wb_dat_o[2:0]                         = state_i;
            wb_dat_o[8 +: `VRX_CMD_DEPTH_LOG2+1] = cmd_count_i;
            wb_dat_o[16]                          = cmd_dropped;
         end
         default:          wb_dat_o = '0;
      endcase
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_ack_o |=> !wb_ack_o)
      else $error("wb_ack_o held for two cycles");

endmodule

`default_nettype wire

/* source/vrx_short_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module vrx_short_fifo
#(
   parameter type payload_t  = logic [31:0],
   parameter int  DEPTH_LOG2 = 4
)
(
   input  wire                   clk,
   input  wire                   arst_n_i,
   input  wire                   flush_i,
   input  wire                   push_i,
   input  wire payload_t         data_i,
   output logic                  full_o,
   input  wire                   pop_i,
   output logic                  empty_o,
   output payload_t              data_o,
   output logic [DEPTH_LOG2:0]   count_o
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   payload_t              mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   assign full_o  = count_o[DEPTH_LOG2];   // Count never exceeds DEPTH
   assign empty_o = (count_o == '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end
      else if (flush_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: count_o <= count_o;   // Both or neither
         endcase
      end
   end

   no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
      pop_i |-> !empty_o)
      else $error("pop_i while queue empty");

   push_full_kept: assert property (@(posedge clk) disable iff (!arst_n_i)
      (push_i && full_o && !pop_i && !flush_i) |=> $stable(count_o))
      else $error("count_o changed on push while full");

endmodule

`default_nettype wire

/* source/vrx_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vrx_defines.svh"

module vrx_control
(
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire                          clear_i,
   input  wire  [63:0]                  vita_time_i,
   input  wire                          cmd_empty_i,
   input  wire  vrx_pkg::vrx_cmd_t      cmd_head_i,
   output logic                         cmd_pop_o,
   input  wire  [`VRX_SAMPLE_W-1:0]     sample_i,
   input  wire                          strobe_i,
   output logic                         run_o,
   output logic                         overrun_o,
   output vrx_pkg::vrx_state_t          state_o,
   input  wire                          smp_full_i,
   output logic                         smp_push_o,
   output vrx_pkg::vrx_smp_entry_t      smp_entry_o
);

   vrx_pkg::vrx_state_t state;
   logic [29:0]         lines_left;
   logic [63:0]         trigger_time;
   logic                send_imm;
   logic                chain;

   logic                time_now;
   logic                time_late;
   logic                go_now;
   logic                too_late;
   logic                last_line;
   logic                next_ready;
   logic                take_sample;
   logic                chain_pop;
   logic                err_state;
   vrx_pkg::vrx_flags_t flags;

   // Time comparison against the loaded trigger
   assign time_now  = (vita_time_i == trigger_time);
   assign time_late = (vita_time_i > trigger_time);
   assign go_now    = time_now | send_imm;
   assign too_late  = time_late & ~send_imm;

   assign run_o     = (state == vrx_pkg::st_running);
   assign overrun_o = (state == vrx_pkg::st_overrun);
   assign state_o   = state;

   assign take_sample = run_o & strobe_i & ~smp_full_i;
   assign last_line   = (lines_left == 30'd1);
   // Chained follow-on with lines still to send
   assign next_ready  = chain & ~cmd_empty_i & (cmd_head_i.num_lines != '0);
   assign chain_pop   = take_sample & last_line & chain;
   assign err_state   = (state == vrx_pkg::st_overrun) |
                        (state == vrx_pkg::st_broken_chain) |
                        (state == vrx_pkg::st_late_cmd);

   assign cmd_pop_o = ~cmd_empty_i & ((state == vrx_pkg::st_idle) | chain_pop);

   always_comb
   begin
      flags.overrun      = (state == vrx_pkg::st_overrun);
      flags.broken_chain = (state == vrx_pkg::st_broken_chain);
      flags.late_cmd     = (state == vrx_pkg::st_late_cmd);
      flags.cmd_done     = run_o & last_line & ~next_ready;
   end

   // Error entries wait here while the queue is full
   assign smp_push_o = ((run_o & strobe_i) | err_state) & ~smp_full_i;

   always_comb
   begin
      smp_entry_o.flags     = flags;
      smp_entry_o.vita_time = vita_time_i;
      smp_entry_o.sample    = err_state ? '0 : sample_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state        <= vrx_pkg::st_idle;
         lines_left   <= '0;
         trigger_time <= '0;
         send_imm     <= 1'b0;
         chain        <= 1'b0;
      end
      else if (clear_i)
      begin
         state        <= vrx_pkg::st_idle;
         lines_left   <= '0;
         trigger_time <= '0;
         send_imm     <= 1'b0;
         chain        <= 1'b0;
      end
      else
      begin
         case (state)
            vrx_pkg::st_idle:
               if (!cmd_empty_i)
               begin
                  lines_left   <= cmd_head_i.num_lines;
                  trigger_time <= cmd_head_i.trigger_time;
                  send_imm     <= cmd_head_i.send_imm;
                  chain        <= cmd_head_i.chain;
                  state        <= vrx_pkg::st_waiting;
               end
            vrx_pkg::st_waiting:
               if (go_now)
                  state <= vrx_pkg::st_running;
               else if (too_late)
                  state <= vrx_pkg::st_late_cmd;
            vrx_pkg::st_running:
               if (strobe_i)
               begin
                  if (smp_full_i)
                     state <= vrx_pkg::st_overrun;   // Sample dropped
                  else
                  begin
                     lines_left <= lines_left - 1'b1;
                     if (last_line)
                     begin
                        if (!chain)
                           state <= vrx_pkg::st_idle;
                        else if (cmd_empty_i)
                           state <= vrx_pkg::st_broken_chain;
                        else
                        begin
                           // Next command continues the stream
                           lines_left   <= cmd_head_i.num_lines;
                           trigger_time <= cmd_head_i.trigger_time;
                           send_imm     <= cmd_head_i.send_imm;
                           chain        <= cmd_head_i.chain;
                           if (cmd_head_i.num_lines == '0)
                              state <= vrx_pkg::st_idle;   // Stop marker
                        end
                     end
                  end
               end
            vrx_pkg::st_overrun, vrx_pkg::st_broken_chain, vrx_pkg::st_late_cmd:
               if (!smp_full_i)
                  state <= vrx_pkg::st_idle;
            default:
               state <= vrx_pkg::st_idle;
         endcase
      end
   end

   // Sample queue never written when it has no room
   no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
      smp_full_i |-> !smp_push_o)
      else $error("smp_push_o while sample queue full");

endmodule

`default_nettype wire

/* source/vrx_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vrx_defines.svh"

module vrx_top
(
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire                          clear_i,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   input  wire                          wb_we_i,
   input  wire  [2:0]                   wb_adr_i,
   input  wire  [31:0]                  wb_dat_i,
   output logic [31:0]                  wb_dat_o,
   output logic                         wb_ack_o,
   input  wire  [63:0]                  vita_time_i,
   input  wire  [`VRX_SAMPLE_W-1:0]     sample_i,
   input  wire                          strobe_i,
   output logic                         run_o,
   output logic                         overrun_o,
   output logic                         smp_valid_o,
   output vrx_pkg::vrx_smp_entry_t      smp_data_o,
   input  wire                          smp_ready_i
);

   logic                         clear_reg;
   logic                         clear_all;
   logic                         cmd_push;
   logic                         cmd_full;
   logic                         cmd_pop;
   logic                         cmd_empty;
   logic [`VRX_CMD_DEPTH_LOG2:0] cmd_count;
   vrx_pkg::vrx_cmd_t            cmd_wr;
   vrx_pkg::vrx_cmd_t            cmd_head;
   vrx_pkg::vrx_state_t          state;
   logic                         smp_push;
   logic                         smp_full;
   logic                         smp_empty;
   logic                         smp_pop;
   vrx_pkg::vrx_smp_entry_t      smp_entry;

   assign clear_all   = clear_i | clear_reg;
   assign smp_valid_o = ~smp_empty;
   assign smp_pop     = smp_valid_o & smp_ready_i;   // Framer handshake

   vrx_wb_regs u_regs (
      .clk(clk), .arst_n_i(arst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .state_i(state), .cmd_count_i(cmd_count), .cmd_full_i(cmd_full),
      .cmd_push_o(cmd_push), .cmd_o(cmd_wr), .clear_o(clear_reg));

   vrx_short_fifo #(.payload_t(vrx_pkg::vrx_cmd_t), .DEPTH_LOG2(`VRX_CMD_DEPTH_LOG2)) u_cmd_q (
      .clk(clk), .arst_n_i(arst_n_i), .flush_i(clear_all),
      .push_i(cmd_push), .data_i(cmd_wr), .full_o(cmd_full),
      .pop_i(cmd_pop), .empty_o(cmd_empty), .data_o(cmd_head), .count_o(cmd_count));

   vrx_short_fifo #(.payload_t(vrx_pkg::vrx_smp_entry_t), .DEPTH_LOG2(`VRX_SMP_DEPTH_LOG2))
      u_smp_q (
      .clk(clk), .arst_n_i(arst_n_i), .flush_i(clear_all),
      .push_i(smp_push), .data_i(smp_entry), .full_o(smp_full),
      .pop_i(smp_pop), .empty_o(smp_empty), .data_o(smp_data_o), .count_o());

   vrx_control u_ctrl (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_all), .vita_time_i(vita_time_i),
      .cmd_empty_i(cmd_empty), .cmd_head_i(cmd_head), .cmd_pop_o(cmd_pop),
      .sample_i(sample_i), .strobe_i(strobe_i), .run_o(run_o), .overrun_o(overrun_o),
      .state_o(state), .smp_full_i(smp_full), .smp_push_o(smp_push),
      .smp_entry_o(smp_entry));

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8
)
(
   output logic clk_o,
   output logic arst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 arst_n_o = 1'b1;   // Released just after an edge
   end

endmodule

`default_nettype wire

/* tests/tb_vrx_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vrx_defines.svh"

module tb_vrx_top;

   localparam int SMP_DEPTH      = 1 << `VRX_SMP_DEPTH_LOG2;
   localparam int TEST_BUDGET    = 3000;   // Cycles allowed per test
   localparam int TIMEOUT_CYCLES = 6 * TEST_BUDGET + 2000;

   logic                      clk;
   logic                      arst_n;
   logic                      clear_i;
   logic                      wb_cyc_i;
   logic                      wb_stb_i;
   logic                      wb_we_i;
   logic [2:0]                wb_adr_i;
   logic [31:0]               wb_dat_i;
   logic [31:0]               wb_dat_o;
   logic                      wb_ack_o;
   logic [63:0]               vita_time_i;
   logic [`VRX_SAMPLE_W-1:0]  sample_i;
   logic                      strobe_i;
   logic                      run_o;
   logic                      overrun_o;
   logic                      smp_valid_o;
   logic                      smp_ready_i;
   vrx_pkg::vrx_smp_entry_t   smp_data_o;

   vrx_pkg::vrx_smp_entry_t   exp_q[$];
   bit                        any_q[$];      // Time tag not predicted
   int                        plan_q[$];     // 0 line, 1 last line, 2 last line then broken chain
   vrx_pkg::vrx_smp_entry_t   exp_head;
   bit                        exp_any;
   bit                        has_exp;
   bit                        ovr_pending;   // Strobe hit a full queue, flagged entry not out yet
   int                        errors;
   int                        cycles;
   integer                    seed;
   logic [63:0]               trig_floor;
   logic [63:0]               prev_tag;
   bit                        prev_ok;
   bit                        consec;
   bit                        no_run;
   logic [31:0]               rd;

   tb_clock u_clock (.clk_o(clk), .arst_n_o(arst_n));

   vrx_top dut (
      .clk(clk), .arst_n_i(arst_n), .clear_i(clear_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .vita_time_i(vita_time_i), .sample_i(sample_i), .strobe_i(strobe_i),
      .run_o(run_o), .overrun_o(overrun_o), .smp_valid_o(smp_valid_o),
      .smp_data_o(smp_data_o), .smp_ready_i(smp_ready_i));

   initial
   begin
      clear_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      vita_time_i = '0;
      sample_i = '0;
      strobe_i = 1'b0;
      smp_ready_i = 1'b1;
      seed = 32'h4c6b;
      errors = 0;
      cycles = 0;
      trig_floor = '0;
      consec = 1'b0;
      prev_ok = 1'b0;
      no_run = 1'b0;
      has_exp = 1'b0;
      ovr_pending = 1'b0;
   end

   // Free-running time and random samples
   always @(posedge clk)
   begin
      #1;
      vita_time_i <= vita_time_i + 64'd1;
      sample_i    <= $random(seed);
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   // Reference model of the sample queue contents
   always @(posedge clk)
   begin : model
      int                      occ;
      int                      code;
      vrx_pkg::vrx_smp_entry_t e;
      if (arst_n)
      begin
         occ = exp_q.size();
         if (smp_valid_o && smp_ready_i && exp_q.size() != 0)
         begin
            e = exp_q.pop_front();
            void'(any_q.pop_front());
            if (e.flags.overrun)
               ovr_pending = 1'b0;
         end
         if (run_o && strobe_i)
         begin
            e = '0;
            if (occ >= SMP_DEPTH)
            begin
               e.flags.overrun = 1'b1;   // Sample dropped, flagged entry later
               exp_q.push_back(e);
               any_q.push_back(1'b1);
               ovr_pending = 1'b1;
            end
            else if (plan_q.size() == 0)
            begin
               errors = errors + 1;
               $display("A sample was accepted while no line was expected");
            end
            else
            begin
               code = plan_q.pop_front();
               e.flags.cmd_done = (code != 0);
               e.vita_time = vita_time_i;
               e.sample = sample_i;
               exp_q.push_back(e);
               any_q.push_back(1'b0);
               assert (vita_time_i >= trig_floor)
               else
               begin
                  errors = errors + 1;
                  $display("Fail vita_time expected >= %h got %h", trig_floor, vita_time_i);
               end
               if (consec && prev_ok)
               begin
                  assert (vita_time_i == prev_tag + 64'd1)
                  else
                  begin
                     errors = errors + 1;
                     $display("Fail vita_time expected %h got %h", prev_tag + 64'd1,
                              vita_time_i);
                  end
               end
               prev_tag = vita_time_i;
               prev_ok = 1'b1;
               if (code == 2)
               begin
                  e = '0;
                  e.flags.broken_chain = 1'b1;
                  e.vita_time = vita_time_i + 64'd1;
                  exp_q.push_back(e);
                  any_q.push_back(1'b0);
               end
            end
         end
         has_exp = (exp_q.size() != 0);
         if (has_exp)
         begin
            exp_head = exp_q[0];
            exp_any = any_q[0];
         end
      end
   end

   transfer_expected: assert property (@(posedge clk) disable iff (!arst_n)
      (smp_valid_o && smp_ready_i) |-> has_exp)
      else
      begin
         errors = errors + 1;
         $display("An entry left the sample queue although none was expected");
      end

   flags_match: assert property (@(posedge clk) disable iff (!arst_n)
      (smp_valid_o && smp_ready_i && has_exp) |-> smp_data_o.flags == exp_head.flags)
      else
      begin
         errors = errors + 1;
         $display("Fail smp_data_o.flags expected %h got %h", $sampled(exp_head.flags),
                  $sampled(smp_data_o.flags));
      end

   sample_match: assert property (@(posedge clk) disable iff (!arst_n)
      (smp_valid_o && smp_ready_i && has_exp) |-> smp_data_o.sample == exp_head.sample)
      else
      begin
         errors = errors + 1;
         $display("Fail smp_data_o.sample expected %h got %h", $sampled(exp_head.sample),
                  $sampled(smp_data_o.sample));
      end

   time_match: assert property (@(posedge clk) disable iff (!arst_n)
      (smp_valid_o && smp_ready_i && has_exp && !exp_any) |->
         smp_data_o.vita_time == exp_head.vita_time)
      else
      begin
         errors = errors + 1;
         $display("Fail smp_data_o.vita_time expected %h got %h",
                  $sampled(exp_head.vita_time), $sampled(smp_data_o.vita_time));
      end

   ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
      else
      begin
         errors = errors + 1;
         $display("Wishbone ack did not come one cycle after the request");
      end

   overrun_in_state: assert property (@(posedge clk) disable iff (!arst_n)
      overrun_o |-> ovr_pending)
      else
      begin
         errors = errors + 1;
         $display("overrun_o was high although no strobe met a full sample queue");
      end

   late_no_run: assert property (@(posedge clk) disable iff (!arst_n)
      no_run |-> !run_o)
      else
      begin
         errors = errors + 1;
         $display("run_o went high for a late command");
      end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      do
         next_cycle();
      while (!wb_ack_o);
      rdat = wb_dat_o;
      next_cycle();   // Ack cycle completes at this edge
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic write_cmd(input logic send_imm, input logic chain, input logic [29:0] lines,
                            input logic [63:0] trig);
      wb_write(`VRX_REG_CMD, {send_imm, chain, lines});
      wb_write(`VRX_REG_TIME_HI, trig[63:32]);
      wb_write(`VRX_REG_TIME_LO, trig[31:0]);
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp_v);
      assert (got == exp_v)
      else
      begin
         errors = errors + 1;
         $display("Fail %s expected %h got %h", name, exp_v, got);
      end
   endtask

   task automatic wait_idle();
      while (plan_q.size() != 0 || exp_q.size() != 0 || smp_valid_o)
         next_cycle();
      repeat (3) next_cycle();
   endtask

   initial
   begin
      @(posedge arst_n);
      next_cycle();

      // Register access
      wb_access(1'b0, `VRX_REG_STATUS, '0, rd);
      check_val("status", rd, 64'h0);
      wb_write(`VRX_REG_CMD, 32'h1234_5678);
      wb_access(1'b0, `VRX_REG_CMD, '0, rd);
      check_val("cmd_reg", rd, 64'h1234_5678);
      wb_write(`VRX_REG_TIME_HI, 32'hA5A5_0000);
      wb_access(1'b0, `VRX_REG_TIME_HI, '0, rd);
      check_val("time_hi", rd, 64'hA5A5_0000);
      wb_write(`VRX_REG_TIME_LO, 32'h0000_1111);   // Far-future trigger
      wb_access(1'b0, `VRX_REG_TIME_LO, '0, rd);
      check_val("time_lo", rd, 64'h0000_1111);
      repeat (3) next_cycle();
      wb_access(1'b0, `VRX_REG_STATUS, '0, rd);
      check_val("status", rd, 64'h1);
      wb_write(`VRX_REG_CLEAR, '0);
      repeat (3) next_cycle();
      wb_access(1'b0, `VRX_REG_STATUS, '0, rd);
      check_val("status", rd, 64'h0);

      // Timed four-line command
      trig_floor = vita_time_i + 64'd40;
      plan_q = '{0, 0, 0, 1};
      write_cmd(1'b0, 1'b0, 30'd4, trig_floor);
      strobe_i = 1'b1;
      wait_idle();
      strobe_i = 1'b0;
      check_val("run_o", run_o, 64'h0);
      trig_floor = '0;

      // Send-immediate chain of three, two and a stop marker
      plan_q = '{0, 0, 0, 0, 1};
      write_cmd(1'b1, 1'b1, 30'd3, 64'd0);
      write_cmd(1'b1, 1'b1, 30'd2, 64'd0);
      write_cmd(1'b1, 1'b0, 30'd0, 64'd0);
      prev_ok = 1'b0;
      consec = 1'b1;
      strobe_i = 1'b1;
      wait_idle();
      strobe_i = 1'b0;
      consec = 1'b0;

      // Late command
      no_run = 1'b1;
      exp_q.push_back('{flags: 4'b0010, vita_time: 64'd0, sample: '0});
      any_q.push_back(1'b1);
      write_cmd(1'b0, 1'b0, 30'd5, 64'd10);
      wait_idle();
      no_run = 1'b0;

      // Broken chain
      plan_q = '{0, 2};
      write_cmd(1'b1, 1'b1, 30'd2, 64'd0);
      strobe_i = 1'b1;
      wait_idle();
      strobe_i = 1'b0;

      // Overrun while the framer stalls
      smp_ready_i = 1'b0;
      for (int i = 0; i < SMP_DEPTH; i++)
         plan_q.push_back(0);
      write_cmd(1'b1, 1'b0, 30'd40, 64'd0);
      strobe_i = 1'b1;
      while (!overrun_o)
         next_cycle();
      strobe_i = 1'b0;
      smp_ready_i = 1'b1;
      wait_idle();

      // Clear flushes a partly filled queue
      smp_ready_i = 1'b0;
      plan_q = '{0, 0, 1};
      write_cmd(1'b1, 1'b0, 30'd3, 64'd0);
      strobe_i = 1'b1;
      while (plan_q.size() != 0)
         next_cycle();
      strobe_i = 1'b0;
      repeat (2) next_cycle();
      check_val("smp_valid_o", smp_valid_o, 64'h1);
      wb_write(`VRX_REG_CLEAR, '0);
      repeat (3) next_cycle();
      exp_q.delete();
      any_q.delete();
      check_val("smp_valid_o", smp_valid_o, 64'h0);
      wb_access(1'b0, `VRX_REG_STATUS, '0, rd);
      check_val("status", rd, 64'h0);
      smp_ready_i = 1'b1;
      repeat (5) next_cycle();

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/vrx_pkg.sv
source/vrx_wb_regs.sv
source/vrx_short_fifo.sv
source/vrx_control.sv
source/vrx_top.sv
tests/tb_clock.sv
tests/tb_vrx_top.sv

/* Makefile */
# Verilator build and regression run

VERILATOR  ?= verilator
TOP        ?= tb_vrx_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
PASS_TEXT  ?= Regression passed

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
